/* rtl/rv_periph_pkg.sv */
/*
  Shared constants for the peripheral subsystem: address map, register
  offsets and sizes. Modules take what they need by a wildcard import.
*/
package rv_periph_pkg;

  // Bus width for address and data
  localparam int XLEN = 32;

  // ========================================
  // Region select, address bits 31 to 24
  // ========================================
  localparam logic [7:0] SEL_CLINT = 8'h02;
  localparam logic [7:0] SEL_PLIC  = 8'h0C;
  localparam logic [7:0] SEL_UART  = 8'h10;
  localparam logic [7:0] SEL_DMEM  = 8'h80;

  // CLINT offsets, high words sit at +4
  localparam logic [15:0] CLINT_MSIP_OFF     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFF = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFF    = 16'hBFF8;

  // UART word register indices, taken from address bits 4 to 2
  localparam logic [2:0] UART_RBR_THR = 3'd0;
  localparam logic [2:0] UART_IER     = 3'd1;
  localparam logic [2:0] UART_LSR     = 3'd5;

  // Line status bit positions
  localparam int LSR_DR   = 0;
  localparam int LSR_THRE = 5;
  localparam int LSR_TEMT = 6;

  localparam int UART_FIFO_DEPTH = 4;

  // ========================================
  // PLIC, id 0 reserved, id 1 UART, 2 to 7 external
  // ========================================
  localparam int PLIC_SOURCES = 8;
  localparam int PLIC_PRIO_W  = 3;

  localparam logic [23:0] PLIC_PENDING_OFF = 24'h001000;
  localparam logic [23:0] PLIC_ENABLE_OFF  = 24'h002000;
  localparam logic [23:0] PLIC_THRESH_OFF  = 24'h200000;
  localparam logic [23:0] PLIC_CLAIM_OFF   = 24'h200004;

  localparam int DMEM_WORDS = 256;

endpackage

/* rtl/periph_bus.sv */
/*
  Single-master request bus. Decodes the top address byte to one of four
  targets, forwards only the offset, and returns the selected ready and
  read data. Unmapped requests are answered here.
*/
`timescale 1ns/1ps

module periph_bus import rv_periph_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  // Master port
  input  logic            req_valid,
  input  logic            req_we,
  input  logic [XLEN-1:0] req_addr,
  input  logic [XLEN-1:0] req_wdata,
  output logic            req_ready,
  output logic [XLEN-1:0] req_rdata,
  // CLINT target
  output logic            clint_valid,
  output logic            clint_we,
  output logic [15:0]     clint_addr,
  output logic [XLEN-1:0] clint_wdata,
  input  logic            clint_ready,
  input  logic [XLEN-1:0] clint_rdata,
  // PLIC target
  output logic            plic_valid,
  output logic            plic_we,
  output logic [23:0]     plic_addr,
  output logic [XLEN-1:0] plic_wdata,
  input  logic            plic_ready,
  input  logic [XLEN-1:0] plic_rdata,
  // UART target
  output logic            uart_valid,
  output logic            uart_we,
  output logic [2:0]      uart_addr,
  output logic [XLEN-1:0] uart_wdata,
  input  logic            uart_ready,
  input  logic [XLEN-1:0] uart_rdata,
  // DMEM target
  output logic            dmem_valid,
  output logic            dmem_we,
  output logic [7:0]      dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  input  logic            dmem_ready,
  input  logic [XLEN-1:0] dmem_rdata
);

  logic hit_clint;
  logic hit_plic;
  logic hit_uart;
  logic hit_dmem;
  logic none_ready;

  // ========================================
  // Address decode, one select for both directions
  // ========================================
  always_comb begin
    hit_clint = 1'b0;
    hit_plic  = 1'b0;
    hit_uart  = 1'b0;
    hit_dmem  = 1'b0;
    case (req_addr[31:24])
      SEL_CLINT: hit_clint = 1'b1;
      SEL_PLIC:  hit_plic  = 1'b1;
      SEL_UART:  hit_uart  = 1'b1;
      SEL_DMEM:  hit_dmem  = 1'b1;
      default: ;
    endcase
  end

  assign clint_valid = req_valid && hit_clint;
  assign plic_valid  = req_valid && hit_plic;
  assign uart_valid  = req_valid && hit_uart;
  assign dmem_valid  = req_valid && hit_dmem;

  // Offsets only, the region byte is dropped
  assign clint_addr = req_addr[15:0];
  assign plic_addr  = req_addr[23:0];
  assign uart_addr  = req_addr[4:2];
  assign dmem_addr  = req_addr[9:2];

  assign clint_we = req_we;
  assign plic_we  = req_we;
  assign uart_we  = req_we;
  assign dmem_we  = req_we;

  assign clint_wdata = req_wdata;
  assign plic_wdata  = req_wdata;
  assign uart_wdata  = req_wdata;
  assign dmem_wdata  = req_wdata;

  // Unmapped access gets the same one-wait-cycle ready as a target
  always_ff @(posedge clk) begin
    if (reset) begin
      none_ready <= 1'b0;
    end else begin
      none_ready <= req_valid && !(hit_clint || hit_plic || hit_uart || hit_dmem)
                    && !none_ready;
    end
  end

  // ========================================
  // Response return
  // ========================================
  always_comb begin
    req_ready = none_ready;
    req_rdata = '0;
    if (hit_clint) begin
      req_ready = clint_ready;
      req_rdata = clint_rdata;
    end else if (hit_plic) begin
      req_ready = plic_ready;
      req_rdata = plic_rdata;
    end else if (hit_uart) begin
      req_ready = uart_ready;
      req_rdata = uart_rdata;
    end else if (hit_dmem) begin
      req_ready = dmem_ready;
      req_rdata = dmem_rdata;
    end
  end

endmodule

/* rtl/clint.sv */
/*
  Core-local interruptor for one hart. Holds the free-running machine
  timer, its compare register and the software-interrupt bit.
*/
`timescale 1ns/1ps

module clint import rv_periph_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid,
  input  logic            we,
  input  logic [15:0]     addr,
  input  logic [XLEN-1:0] wdata,
  output logic            ready,
  output logic [XLEN-1:0] rdata,
  output logic            mtip,
  output logic            msip
);

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        msip_reg;
  logic        wr_en;

  // Side effects land in the ready cycle
  assign wr_en = valid && ready && we;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;
    end
  end

  // ========================================
  // Timer, compare and software interrupt
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      mtime    <= '0;
      mtimecmp <= '1;
      msip_reg <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (wr_en) begin
        case (addr)
          CLINT_MSIP_OFF:             msip_reg        <= wdata[0];
          CLINT_MTIMECMP_OFF:         mtimecmp[31:0]  <= wdata;
          CLINT_MTIMECMP_OFF + 16'd4: mtimecmp[63:32] <= wdata;
          // A write to the timer wins over the increment
          CLINT_MTIME_OFF:            mtime[31:0]     <= wdata;
          CLINT_MTIME_OFF + 16'd4:    mtime[63:32]    <= wdata;
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_comb begin
    case (addr)
      CLINT_MSIP_OFF:             rdata = {{(XLEN-1){1'b0}}, msip_reg};
      CLINT_MTIMECMP_OFF:         rdata = mtimecmp[31:0];
      CLINT_MTIMECMP_OFF + 16'd4: rdata = mtimecmp[63:32];
      CLINT_MTIME_OFF:            rdata = mtime[31:0];
      CLINT_MTIME_OFF + 16'd4:    rdata = mtime[63:32];
      default:                    rdata = '0;
    endcase
  end

  // Level outputs straight from registers
  assign mtip = (mtime >= mtimecmp);
  assign msip = msip_reg;

endmodule

/* rtl/uart_16550.sv */
/*
  16550-style UART register block. THR writes feed a transmit FIFO that
  drains to the tx byte stream; the rx stream fills a receive FIFO that
  RBR reads pop. LSR and IER follow the usual bit layout.
*/
`timescale 1ns/1ps

module uart_16550 import rv_periph_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid,
  input  logic            we,
  input  logic [2:0]      addr,
  input  logic [XLEN-1:0] wdata,
  output logic            ready,
  output logic [XLEN-1:0] rdata,
  output logic            tx_valid,
  output logic [7:0]      tx_data,
  input  logic            tx_ready,
  input  logic            rx_valid,
  input  logic [7:0]      rx_data,
  output logic            rx_ready,
  output logic            irq
);

  localparam int PW = $clog2(UART_FIFO_DEPTH);

  // FIFO 0 is transmit, FIFO 1 is receive
  logic [7:0]    fifo_mem [2][UART_FIFO_DEPTH];
  logic [PW-1:0] wr_ptr [2];
  logic [PW-1:0] rd_ptr [2];
  logic [PW:0]   count [2];
  logic [7:0]    push_data [2];
  logic [1:0]    push;
  logic [1:0]    pop;
  logic [1:0]    full;
  logic [1:0]    empty;
  logic [1:0]    ier;
  logic          access;
  logic [7:0]    lsr;

  assign access = valid && ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;
    end
  end

  // ========================================
  // FIFO control
  // ========================================
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      full[i]  = (count[i] == (PW+1)'(UART_FIFO_DEPTH));
      empty[i] = (count[i] == '0);
    end
    // THR write is dropped when the transmit FIFO is full
    push[0]      = access && we && (addr == UART_RBR_THR) && !full[0];
    push_data[0] = wdata[7:0];
    pop[0]       = tx_valid && tx_ready;
    push[1]      = rx_valid && rx_ready;
    push_data[1] = rx_data;
    pop[1]       = access && !we && (addr == UART_RBR_THR) && !empty[1];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        count[i]  <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (push[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
        if (pop[i]) rd_ptr[i] <= rd_ptr[i] + 1'b1;
        count[i] <= count[i] + (PW+1)'(push[i]) - (PW+1)'(pop[i]);
      end
    end
  end

  // Storage, no reset
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (push[i]) fifo_mem[i][wr_ptr[i]] <= push_data[i];
    end
  end

  // Byte streams
  assign tx_valid = !empty[0];
  assign tx_data  = fifo_mem[0][rd_ptr[0]];
  assign rx_ready = !full[1];

  // ========================================
  // Registers and read mux
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      ier <= '0;
    end else if (access && we && (addr == UART_IER)) begin
      ier <= wdata[1:0];
    end
  end

  always_comb begin
    lsr           = '0;
    lsr[LSR_DR]   = !empty[1];
    lsr[LSR_THRE] = !full[0];
    lsr[LSR_TEMT] = empty[0];
  end

  always_comb begin
    case (addr)
      // Empty RBR reads as zero
      UART_RBR_THR: rdata = empty[1] ? '0 : XLEN'(fifo_mem[1][rd_ptr[1]]);
      UART_IER:     rdata = XLEN'(ier);
      UART_LSR:     rdata = XLEN'(lsr);
      default:      rdata = '0;
    endcase
  end

  // Receive data waiting or transmitter empty
  assign irq = (ier[0] && !empty[1]) || (ier[1] && empty[0]);

endmodule

/* rtl/plic.sv */
/*
  Reduced platform interrupt controller with one machine context.
  Level gateways set pending bits; claim picks the highest priority
  enabled source above threshold, lowest id on a tie.
*/
`timescale 1ns/1ps

module plic import rv_periph_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    valid,
  input  logic                    we,
  input  logic [23:0]             addr,
  input  logic [XLEN-1:0]         wdata,
  output logic                    ready,
  output logic [XLEN-1:0]         rdata,
  input  logic [PLIC_SOURCES-1:0] irq_src,
  output logic                    meip
);

  localparam int ID_W = $clog2(PLIC_SOURCES);

  logic [PLIC_SOURCES-1:0][PLIC_PRIO_W-1:0] prio;
  logic [PLIC_SOURCES-1:0] pending;
  logic [PLIC_SOURCES-1:0] enable;
  logic [PLIC_SOURCES-1:0] in_service;
  logic [PLIC_PRIO_W-1:0]  threshold;
  logic [PLIC_PRIO_W-1:0]  best_prio;
  logic [ID_W-1:0]         best_id;
  logic                    access;
  logic                    prio_sel;

  assign access   = valid && ready;
  // Priority words fill the first 4 KiB, source n at 4n
  assign prio_sel = (addr[23:12] == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;
    end
  end

  // ========================================
  // Candidate search
  // ========================================
  always_comb begin
    best_prio = threshold;
    best_id   = '0;
    // Strict compare keeps the lowest id among equal priorities
    for (int i = 1; i < PLIC_SOURCES; i++) begin
      if (pending[i] && enable[i] && (prio[i] > best_prio)) begin
        best_prio = prio[i];
        best_id   = ID_W'(i);
      end
    end
  end

  assign meip = (best_id != '0);

  // ========================================
  // Gateways, configuration, claim and complete
  // ========================================
  always_ff @(posedge clk) begin
    if (reset) begin
      prio       <= '0;
      pending    <= '0;
      enable     <= '0;
      in_service <= '0;
      threshold  <= '0;
    end else begin
      // Level source sets pending unless it is still in service
      for (int i = 1; i < PLIC_SOURCES; i++) begin
        if (irq_src[i] && !in_service[i]) pending[i] <= 1'b1;
      end
      if (access && we) begin
        if (prio_sel) begin
          prio[addr[ID_W+1:2]] <= wdata[PLIC_PRIO_W-1:0];
        end else if (addr == PLIC_ENABLE_OFF) begin
          enable <= wdata[PLIC_SOURCES-1:0];
        end else if (addr == PLIC_THRESH_OFF) begin
          threshold <= wdata[PLIC_PRIO_W-1:0];
        end else if (addr == PLIC_CLAIM_OFF) begin
          in_service[wdata[ID_W-1:0]] <= 1'b0;
        end
      end
      // Claim clears pending after the gateway update
      if (access && !we && (addr == PLIC_CLAIM_OFF) && meip) begin
        pending[best_id]    <= 1'b0;
        in_service[best_id] <= 1'b1;
      end
    end
  end

  // Read mux, pending is read only
  always_comb begin
    rdata = '0;
    if (prio_sel) begin
      rdata = XLEN'(prio[addr[ID_W+1:2]]);
    end else if (addr == PLIC_PENDING_OFF) begin
      rdata = XLEN'(pending);
    end else if (addr == PLIC_ENABLE_OFF) begin
      rdata = XLEN'(enable);
    end else if (addr == PLIC_THRESH_OFF) begin
      rdata = XLEN'(threshold);
    end else if (addr == PLIC_CLAIM_OFF) begin
      rdata = XLEN'(best_id);
    end
  end

endmodule

/* rtl/dmem.sv */
/*
  Word-addressed data memory on the request bus. Read data and the
  one-cycle ready are registered; only ready is cleared by reset.
*/
`timescale 1ns/1ps

module dmem import rv_periph_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            valid,
  input  logic            we,
  input  logic [7:0]      addr,
  input  logic [XLEN-1:0] wdata,
  output logic            ready,
  output logic [XLEN-1:0] rdata
);

  logic [XLEN-1:0] mem [DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (reset) begin
      ready <= 1'b0;
    end else begin
      ready <= valid && !ready;
    end
  end

  // Read captured on the first cycle, write done in the ready cycle
  always_ff @(posedge clk) begin
    if (valid) rdata <= mem[addr];
    if (valid && ready && we) mem[addr] <= wdata;
  end

endmodule

/* rtl/rv_periph.sv */
/*
  Peripheral subsystem top level. One request bus master port, UART
  byte streams, external interrupt lines in, and the machine timer,
  software and external interrupt lines out.
*/
`timescale 1ns/1ps

module rv_periph import rv_periph_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            req_valid,
  input  logic            req_we,
  input  logic [XLEN-1:0] req_addr,
  input  logic [XLEN-1:0] req_wdata,
  output logic            req_ready,
  output logic [XLEN-1:0] req_rdata,
  output logic            tx_valid,
  output logic [7:0]      tx_data,
  input  logic            tx_ready,
  input  logic            rx_valid,
  input  logic [7:0]      rx_data,
  output logic            rx_ready,
  input  logic [5:0]      ext_irq,
  output logic            mtip,
  output logic            msip,
  output logic            meip
);

  // Target-side bus signals
  logic            clint_valid, clint_we, clint_ready;
  logic [15:0]     clint_addr;
  logic [XLEN-1:0] clint_wdata, clint_rdata;
  logic            plic_valid, plic_we, plic_ready;
  logic [23:0]     plic_addr;
  logic [XLEN-1:0] plic_wdata, plic_rdata;
  logic            uart_valid, uart_we, uart_ready;
  logic [2:0]      uart_addr;
  logic [XLEN-1:0] uart_wdata, uart_rdata;
  logic            dmem_valid, dmem_we, dmem_ready;
  logic [7:0]      dmem_addr;
  logic [XLEN-1:0] dmem_wdata, dmem_rdata;
  logic            uart_irq;
  logic [PLIC_SOURCES-1:0] irq_src;

  // Source 0 reserved, UART on 1, external lines on 2 to 7
  assign irq_src = {ext_irq, uart_irq, 1'b0};

  // ========================================
  // Bus and targets
  // ========================================
  periph_bus u_periph_bus (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_we(req_we), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_ready(req_ready), .req_rdata(req_rdata),
    .clint_valid(clint_valid), .clint_we(clint_we), .clint_addr(clint_addr),
    .clint_wdata(clint_wdata), .clint_ready(clint_ready), .clint_rdata(clint_rdata),
    .plic_valid(plic_valid), .plic_we(plic_we), .plic_addr(plic_addr),
    .plic_wdata(plic_wdata), .plic_ready(plic_ready), .plic_rdata(plic_rdata),
    .uart_valid(uart_valid), .uart_we(uart_we), .uart_addr(uart_addr),
    .uart_wdata(uart_wdata), .uart_ready(uart_ready), .uart_rdata(uart_rdata),
    .dmem_valid(dmem_valid), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_ready(dmem_ready), .dmem_rdata(dmem_rdata)
  );

  clint u_clint (
    .clk(clk), .reset(reset),
    .valid(clint_valid), .we(clint_we), .addr(clint_addr), .wdata(clint_wdata),
    .ready(clint_ready), .rdata(clint_rdata),
    .mtip(mtip), .msip(msip)
  );

  uart_16550 u_uart (
    .clk(clk), .reset(reset),
    .valid(uart_valid), .we(uart_we), .addr(uart_addr), .wdata(uart_wdata),
    .ready(uart_ready), .rdata(uart_rdata),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
    .irq(uart_irq)
  );

  plic u_plic (
    .clk(clk), .reset(reset),
    .valid(plic_valid), .we(plic_we), .addr(plic_addr), .wdata(plic_wdata),
    .ready(plic_ready), .rdata(plic_rdata),
    .irq_src(irq_src), .meip(meip)
  );

  dmem u_dmem (
    .clk(clk), .reset(reset),
    .valid(dmem_valid), .we(dmem_we), .addr(dmem_addr), .wdata(dmem_wdata),
    .ready(dmem_ready), .rdata(dmem_rdata)
  );

endmodule

/* testbench/tb_clock.sv */
/*
  Free-running testbench clock, starting low, 40 ns period by default.
*/
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // Half period per toggle
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

/* testbench/tb_rv_periph.sv */
/*
  Testbench for the peripheral subsystem. Reads one operation per line
  from the tests file, drives the request bus and UART streams, and
  compares bus reads, tx bytes and interrupt lines with the file.
*/
`timescale 1ns/1ps

module tb_rv_periph;

  localparam int WAIT_LIMIT = 200;
  localparam int DRIVE_DLY  = 2;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_we;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic        req_ready;
  logic [31:0] req_rdata;
  logic        tx_valid;
  logic [7:0]  tx_data;
  logic        tx_ready;
  logic        rx_valid;
  logic [7:0]  rx_data;
  logic        rx_ready;
  logic [5:0]  ext_irq;
  logic        mtip;
  logic        msip;
  logic        meip;

  logic [31:0] rng_state;
  logic [31:0] prev_mtime;
  int          op_count;

  tb_clock #(.PERIOD_NS(40)) u_tb_clock (.clk(clk));

  rv_periph u_rv_periph (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_we(req_we), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_ready(req_ready), .req_rdata(req_rdata),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
    .ext_irq(ext_irq), .mtip(mtip), .msip(msip), .meip(meip)
  );

  // ========================================
  // Helpers
  // ========================================
  // 32-bit xorshift step for tx_ready stalls
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Line select as used in the tests file
  function automatic logic irq_line(input logic [31:0] sel);
    case (sel)
      32'd0:   return mtip;
      32'd1:   return msip;
      default: return meip;
    endcase
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  // One bus transfer; called and left at posedge plus DRIVE_DLY
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   cycles;
    logic done;
    cycles    = 0;
    done      = 1'b0;
    rdata     = '0;
    req_valid = 1'b1;
    req_we    = we;
    req_addr  = addr;
    req_wdata = wdata;
    while (!done) begin
      // Ready and read data sampled mid-cycle
      @(negedge clk);
      cycles++;
      if (req_ready) begin
        done  = 1'b1;
        rdata = req_rdata;
      end else if (cycles >= WAIT_LIMIT) begin
        $display("Timeout: no req_ready for the access to address %h", addr);
        abort_run();
      end
      @(posedge clk);
      #DRIVE_DLY;
    end
    req_valid = 1'b0;
    req_we    = 1'b0;
    // Every access takes exactly two cycles of req_valid
    check_value(32'(cycles), 32'd2, $sformatf("ready cycle of access to %h", addr));
  endtask

  task automatic push_rx(input logic [7:0] data);
    int   cycles;
    logic done;
    cycles   = 0;
    done     = 1'b0;
    rx_valid = 1'b1;
    rx_data  = data;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (rx_ready) begin
        done = 1'b1;
      end else if (cycles >= WAIT_LIMIT) begin
        $display("Timeout: rx_ready stayed low while pushing byte %h", data);
        abort_run();
      end
      @(posedge clk);
      #DRIVE_DLY;
    end
    rx_valid = 1'b0;
  endtask

  // Random stalls on tx_ready until one byte is taken
  task automatic expect_tx(input logic [7:0] expected);
    int         cycles;
    logic       done;
    logic [7:0] seen;
    cycles = 0;
    done   = 1'b0;
    seen   = '0;
    while (!done) begin
      rng_state = xorshift32(rng_state);
      tx_ready  = rng_state[0];
      @(negedge clk);
      cycles++;
      if (tx_valid && tx_ready) begin
        done = 1'b1;
        seen = tx_data;
      end else if (cycles >= WAIT_LIMIT) begin
        $display("Timeout: no byte appeared on the tx stream, expected %h", expected);
        abort_run();
      end
      @(posedge clk);
      #DRIVE_DLY;
    end
    tx_ready = 1'b0;
    check_value({24'd0, seen}, {24'd0, expected}, "tx byte");
  endtask

  task automatic wait_line(input logic [31:0] sel, input logic level);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge clk);
      cycles++;
      seen = (irq_line(sel) == level);
      if (!seen && cycles >= WAIT_LIMIT) begin
        $display("Timeout: interrupt line %0d never reached %0b", sel, level);
        abort_run();
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // ========================================
  // Tests file interpreter
  // ========================================
  task automatic run_tests_file();
    int          fd;
    int          n;
    int          ch;
    logic        stop;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] rd;
    stop = 1'b0;
    fd   = $fopen("testbench/rv_periph_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/rv_periph_tests.txt for reading");
      abort_run();
    end
    while (!stop) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) begin
        stop = 1'b1;
      end else if (op == "#") begin
        // Skip a comment line
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) ch = $fgetc(fd);
      end else begin
        n = $fscanf(fd, "%h %h %h", addr, data, expected);
        if (n != 3) begin
          $display("Tests file line for operation %c has missing fields", op);
          abort_run();
        end
        op_count++;
        case (op)
          "W": bus_access(1'b1, addr, data, rd);
          "R": begin
            bus_access(1'b0, addr, 32'h0, rd);
            check_value(rd, expected, $sformatf("read of %h", addr));
          end
          // Timer must move forward between reads
          "G": begin
            bus_access(1'b0, addr, 32'h0, rd);
            check_value(32'(rd > prev_mtime), 32'd1, $sformatf("timer read %h", rd));
            prev_mtime = rd;
          end
          "P": push_rx(data[7:0]);
          "T": expect_tx(expected[7:0]);
          "E": ext_irq = data[5:0];
          "I": wait_line(addr, expected[0]);
          default: begin
            $display("Unknown operation %c in the tests file", op);
            abort_run();
          end
        endcase
      end
    end
    $fclose(fd);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    reset      = 1'b1;
    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    tx_ready   = 1'b0;
    rx_valid   = 1'b0;
    rx_data    = '0;
    ext_irq    = '0;
    rng_state  = 32'd35;
    prev_mtime = '0;
    op_count   = 0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;
    run_tests_file();
    $display("%0d operations run", op_count);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* rv_periph.f */
rtl/rv_periph_pkg.sv
rtl/periph_bus.sv
rtl/clint.sv
rtl/uart_16550.sv
rtl/plic.sv
rtl/dmem.sv
rtl/rv_periph.sv
testbench/tb_clock.sv
testbench/tb_rv_periph.sv

/* run.sh */
#!/bin/sh
# Build the rv_periph testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_rv_periph \
  -f rv_periph.f -o sim_rv_periph
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_rv_periph
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

/* testbench/rv_periph_tests.txt */
# op addr data expect, fields in hex; W write, R read, G timer read above last
# P push rx byte, T expect tx byte, E set ext_irq, I wait line (0 mtip 1 msip 2 meip)
I 00000000 00000000 00000000
I 00000001 00000000 00000000
I 00000002 00000000 00000000
# Data memory and unmapped decode
W 80000000 11223344 00000000
W 80000004 a5a5a5a5 00000000
W 800003fc deadbeef 00000000
R 80000000 00000000 11223344
R 80000004 00000000 a5a5a5a5
R 800003fc 00000000 deadbeef
R 40000000 00000000 00000000
W 40000000 12345678 00000000
R 40000000 00000000 00000000
# CLINT software interrupt, timer and compare
W 02000000 00000001 00000000
I 00000001 00000000 00000001
R 02000000 00000000 00000001
W 02000000 00000000 00000000
I 00000001 00000000 00000000
R 02004004 00000000 ffffffff
G 0200bff8 00000000 00000000
G 0200bff8 00000000 00000000
W 02004004 00000000 00000000
W 02004000 00000010 00000000
I 00000000 00000000 00000001
W 02004000 ffffffff 00000000
W 02004004 ffffffff 00000000
I 00000000 00000000 00000000
# UART transmit, fifth byte dropped on a full FIFO
R 10000014 00000000 00000060
W 10000000 00000031 00000000
W 10000000 00000032 00000000
W 10000000 00000033 00000000
W 10000000 00000034 00000000
R 10000014 00000000 00000000
W 10000000 00000035 00000000
T 00000000 00000000 00000031
T 00000000 00000000 00000032
T 00000000 00000000 00000033
T 00000000 00000000 00000034
R 10000014 00000000 00000060
# UART receive
P 00000000 00000041 00000000
P 00000000 00000042 00000000
P 00000000 00000043 00000000
R 10000014 00000000 00000061
R 10000000 00000000 00000041
R 10000000 00000000 00000042
R 10000000 00000000 00000043
R 10000014 00000000 00000060
R 10000000 00000000 00000000
# PLIC priorities 1:2 2:5 3:5 4:3 5:1, threshold 1, enable 1 to 5
W 0c000004 00000002 00000000
W 0c000008 00000005 00000000
W 0c00000c 00000005 00000000
W 0c000010 00000003 00000000
W 0c000014 00000001 00000000
W 0c200000 00000001 00000000
W 0c002000 0000003e 00000000
R 0c000008 00000000 00000005
I 00000002 00000000 00000000
E 00000000 0000000f 00000000
W 10000004 00000002 00000000
I 00000002 00000000 00000001
R 0c001000 00000000 0000003e
R 0c200004 00000000 00000002
R 0c200004 00000000 00000003
R 0c200004 00000000 00000004
R 0c200004 00000000 00000001
R 0c200004 00000000 00000000
I 00000002 00000000 00000000
# Complete source 2 while it is still high
W 0c200004 00000002 00000000
I 00000002 00000000 00000001
R 0c200004 00000000 00000002
E 00000000 00000000 00000000
W 10000004 00000000 00000000
W 0c200004 00000002 00000000
W 0c200004 00000003 00000000
W 0c200004 00000004 00000000
W 0c200004 00000001 00000000
R 0c001000 00000000 00000020
R 0c200004 00000000 00000000
I 00000002 00000000 00000000
